//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

  // Instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  // Primary opcodes
  localparam opcode_t opcodeRType = 6'b000000;
  localparam opcode_t opcodeJ     = 6'b000010;
  localparam opcode_t opcodeJal   = 6'b000011;
  localparam opcode_t opcodeAddi  = 6'b001000;
  localparam opcode_t opcodeAddiu = 6'b001001;
  localparam opcode_t opcodeSlti  = 6'b001010;
  localparam opcode_t opcodeLui   = 6'b001111;
  localparam opcode_t opcodeSw    = 6'b101011;

  // R-type function codes
  localparam funct_t functXchg  = 6'b000101;
  localparam funct_t functJr    = 6'b001000;
  localparam funct_t functBreak = 6'b001101;
  localparam funct_t functMfhi  = 6'b010000;
  localparam funct_t functMflo  = 6'b010010;
  localparam funct_t functRte   = 6'b010011;
  localparam funct_t functAdd   = 6'b100000;
  localparam funct_t functSub   = 6'b100010;
  localparam funct_t functAnd   = 6'b100100;
  localparam funct_t functSlt   = 6'b101010;

  // One class per supported instruction
  typedef enum logic [4:0] {
    classAdd,
    classSub,
    classAnd,
    classSlt,
    classAddi,
    classAddiu,
    classSlti,
    classLui,
    classMfhi,
    classMflo,
    classJ,
    classJal,
    classJr,
    classSw,
    classBreak,
    classRte,
    classXchg,
    classInvalid
  } instrClass_t;

endpackage

`default_nettype wire

//--- common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // ALU operation
  typedef logic [2:0] aluOp_t;
  localparam aluOp_t aluPass = 3'b000;
  localparam aluOp_t aluAdd  = 3'b001;
  localparam aluOp_t aluSub  = 3'b010;
  localparam aluOp_t aluAnd  = 3'b011;
  localparam aluOp_t aluSlt  = 3'b111;

  // ALU operand selects
  typedef logic [1:0] aluSrcB_t;
  localparam aluSrcB_t srcBRegB = 2'b00;
  localparam aluSrcB_t srcBFour = 2'b01;
  localparam aluSrcB_t srcBImm  = 2'b10;

  typedef logic [0:0] aluSrcA_t;
  localparam aluSrcA_t srcAPc   = 1'b0;
  localparam aluSrcA_t srcARegA = 1'b1;

  // Register file destination
  typedef logic [2:0] regDst_t;
  localparam regDst_t dstRt = 3'b000;
  localparam regDst_t dstRd = 3'b001;
  localparam regDst_t dstRa = 3'b010;
  localparam regDst_t dstRs = 3'b100;

  // Write-back source
  typedef logic [3:0] memToReg_t;
  localparam memToReg_t wbAlu   = 4'b0000;
  localparam memToReg_t wbHi    = 4'b0010;
  localparam memToReg_t wbLo    = 4'b0011;
  localparam memToReg_t wbXchgB = 4'b0111;
  localparam memToReg_t wbLui   = 4'b1000;
  localparam memToReg_t wbXchgA = 4'b1001;
  localparam memToReg_t wbSlt   = 4'b1010;

  // Memory address source, 000 when memory is idle
  typedef logic [2:0] iorD_t;
  localparam iorD_t addrPc  = 3'b011;
  localparam iorD_t addrAlu = 3'b100;

  typedef logic [1:0] pcSource_t;
  localparam pcSource_t pcAlu    = 2'b00;
  localparam pcSource_t pcJump   = 2'b01;
  localparam pcSource_t pcVector = 2'b10;
  localparam pcSource_t pcEpc    = 2'b11;

  typedef logic [0:0] excCause_t;
  localparam excCause_t causeOverflow = 1'b0;
  localparam excCause_t causeInvalid  = 1'b1;

  typedef struct packed {
    logic pcWrite;
    logic aWrite;
    logic bWrite;
    logic epcWrite;
    logic irWrite;
    logic regWrite;
    logic memWrite;
    aluOp_t aluOp;
    aluSrcA_t aluSrcA;
    aluSrcB_t aluSrcB;
    regDst_t regDst;
    memToReg_t memToReg;
    iorD_t iorD;
    pcSource_t pcSource;
    excCause_t excCause;
  } ctrlWord_t;

  localparam ctrlWord_t ctrlIdle = '0;

  typedef enum logic [3:0] {
    stReset,
    stFetchRead0,
    stFetchRead1,
    stFetchIncr,
    stIrLoad,
    stDecode,
    stExecute,
    stExecute2,
    stTrapOverflow,
    stTrapInvalid
  } seqState_t;

endpackage

`default_nettype wire

//--- logic/opcodeDecoder.sv
`default_nettype none

module opcodeDecoder (
  input wire isaPkg::opcode_t opcode,
  input wire isaPkg::funct_t funct,
  output isaPkg::instrClass_t instrClass
);

  import isaPkg::*;

  always_comb begin
    instrClass = classInvalid;
    if (opcode == opcodeRType) begin
      // R-type is identified by funct alone
      case (funct)
        functAdd: instrClass = classAdd;
        functSub: instrClass = classSub;
        functAnd: instrClass = classAnd;
        functSlt: instrClass = classSlt;
        functMfhi: instrClass = classMfhi;
        functMflo: instrClass = classMflo;
        functJr: instrClass = classJr;
        functBreak: instrClass = classBreak;
        functRte: instrClass = classRte;
        functXchg: instrClass = classXchg;
        default: instrClass = classInvalid;
      endcase
    end else begin
      case (opcode)
        opcodeAddi: instrClass = classAddi;
        opcodeAddiu: instrClass = classAddiu;
        opcodeSlti: instrClass = classSlti;
        opcodeLui: instrClass = classLui;
        opcodeSw: instrClass = classSw;
        opcodeJ: instrClass = classJ;
        // jal has its own opcode
        opcodeJal: instrClass = classJal;
        default: instrClass = classInvalid;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- controlSequencer/controlSequencer.sv
`default_nettype none

module controlSequencer (
  input wire clk,
  input wire reset,
  input wire isaPkg::instrClass_t instrClass,
  input wire overflow,
  output ctrlPkg::seqState_t state
);

  import isaPkg::*;
  import ctrlPkg::*;

  seqState_t nextState;
  logic overflowTraps;

  // Only signed arithmetic traps on overflow
  assign overflowTraps = instrClass inside {classAdd, classSub, classAddi};

  always_comb begin
    nextState = stReset;
    case (state)
      // One idle cycle after reset release
      stReset: nextState = stFetchRead0;

      // Fixed fetch and decode sequence
      stFetchRead0: nextState = stFetchRead1;
      stFetchRead1: nextState = stFetchIncr;
      stFetchIncr: nextState = stIrLoad;
      stIrLoad: nextState = stDecode;

      stDecode: begin
        if (instrClass == classInvalid) begin
          nextState = stTrapInvalid;
        end else begin
          nextState = stExecute;
        end
      end

      stExecute: begin
        if (instrClass == classXchg) begin
          nextState = stExecute2;
        end else if (overflowTraps && overflow) begin
          // Register write already happened this cycle
          nextState = stTrapOverflow;
        end else begin
          nextState = stFetchRead0;
        end
      end

      stExecute2: nextState = stFetchRead0;
      stTrapOverflow: nextState = stFetchRead0;
      stTrapInvalid: nextState = stFetchRead0;

      default: nextState = stReset;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReset;
    end else begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

//--- logic/controlSignalTable.sv
`default_nettype none

module controlSignalTable (
  input wire ctrlPkg::seqState_t state,
  input wire isaPkg::instrClass_t instrClass,
  output ctrlPkg::ctrlWord_t ctrl,
  output logic resetOut
);

  import isaPkg::*;
  import ctrlPkg::*;

  // Register write of an ALU result
  function automatic ctrlWord_t regAluWord(aluOp_t op, aluSrcB_t srcB, regDst_t dst,
                                           memToReg_t wb);
    ctrlWord_t w;
    w = ctrlIdle;
    w.regWrite = 1'b1;
    w.aluOp = op;
    w.aluSrcA = srcARegA;
    w.aluSrcB = srcB;
    w.regDst = dst;
    w.memToReg = wb;
    return w;
  endfunction

  // Register write that bypasses the ALU
  function automatic ctrlWord_t regMoveWord(regDst_t dst, memToReg_t wb);
    ctrlWord_t w;
    w = ctrlIdle;
    w.regWrite = 1'b1;
    w.regDst = dst;
    w.memToReg = wb;
    return w;
  endfunction

  function automatic ctrlWord_t execWord(instrClass_t cls);
    ctrlWord_t w;
    w = ctrlIdle;
    case (cls)
      classAdd: w = regAluWord(aluAdd, srcBRegB, dstRd, wbAlu);
      classSub: w = regAluWord(aluSub, srcBRegB, dstRd, wbAlu);
      classAnd: w = regAluWord(aluAnd, srcBRegB, dstRd, wbAlu);
      classSlt: w = regAluWord(aluSlt, srcBRegB, dstRd, wbSlt);
      classAddi, classAddiu: w = regAluWord(aluAdd, srcBImm, dstRt, wbAlu);
      classSlti: w = regAluWord(aluSlt, srcBImm, dstRt, wbSlt);
      classLui: w = regMoveWord(dstRt, wbLui);
      classMfhi: w = regMoveWord(dstRd, wbHi);
      classMflo: w = regMoveWord(dstRd, wbLo);
      classXchg: w = regMoveWord(dstRt, wbXchgA);
      classJ, classJal: begin
        w.pcWrite = 1'b1;
        w.pcSource = pcJump;
        // Link into ra
        if (cls == classJal) begin
          w.regWrite = 1'b1;
          w.regDst = dstRa;
        end
      end
      classJr: begin
        w.pcWrite = 1'b1;
        w.aluOp = aluPass;
        w.aluSrcA = srcARegA;
        w.pcSource = pcAlu;
        w.iorD = addrPc;
      end
      classSw: begin
        w.memWrite = 1'b1;
        w.aluOp = aluAdd;
        w.aluSrcA = srcARegA;
        w.aluSrcB = srcBImm;
        w.iorD = addrAlu;
      end
      // PC was already advanced, step back onto the break
      classBreak: begin
        w.pcWrite = 1'b1;
        w.aluOp = aluSub;
        w.aluSrcA = srcAPc;
        w.aluSrcB = srcBFour;
        w.pcSource = pcAlu;
        w.iorD = addrPc;
      end
      classRte: begin
        w.pcWrite = 1'b1;
        w.pcSource = pcEpc;
        w.iorD = addrPc;
      end
      default: w = ctrlIdle;
    endcase
    return w;
  endfunction

  always_comb begin
    ctrl = ctrlIdle;
    case (state)
      stFetchRead0, stFetchRead1: ctrl.iorD = addrPc;
      stFetchIncr: begin
        ctrl.pcWrite = 1'b1;
        ctrl.aluOp = aluAdd;
        ctrl.aluSrcA = srcAPc;
        ctrl.aluSrcB = srcBFour;
        ctrl.pcSource = pcAlu;
      end
      stIrLoad: ctrl.irWrite = 1'b1;
      stDecode: begin
        ctrl.aWrite = 1'b1;
        ctrl.bWrite = 1'b1;
      end
      stExecute: ctrl = execWord(instrClass);
      // Second half of xchg
      stExecute2: ctrl = regMoveWord(dstRs, wbXchgB);
      stTrapOverflow, stTrapInvalid: begin
        ctrl.epcWrite = 1'b1;
        ctrl.pcWrite = 1'b1;
        ctrl.pcSource = pcVector;
        ctrl.excCause = (state == stTrapInvalid) ? causeInvalid : causeOverflow;
      end
      default: ctrl = ctrlIdle;
    endcase
  end

  assign resetOut = (state == stReset);

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`default_nettype none

module controlUnit (
  input wire clk,
  input wire reset,
  input wire isaPkg::opcode_t opcode,
  input wire isaPkg::funct_t funct,
  input wire overflow,
  output wire ctrlPkg::ctrlWord_t ctrl,
  output wire resetOut
);

  import isaPkg::*;
  import ctrlPkg::*;

  instrClass_t instrClass;
  seqState_t state;

  opcodeDecoder decoder (
    .opcode(opcode),
    .funct(funct),
    .instrClass(instrClass)
  );

  controlSequencer sequencer (
    .clk(clk),
    .reset(reset),
    .instrClass(instrClass),
    .overflow(overflow),
    .state(state)
  );

  // Moore outputs from the registered state
  controlSignalTable signalTable (
    .state(state),
    .instrClass(instrClass),
    .ctrl(ctrl),
    .resetOut(resetOut)
  );

endmodule

`default_nettype wire

//--- dv/controlUnitVectors.svh
`ifndef CONTROL_UNIT_VECTORS_SVH
`define CONTROL_UNIT_VECTORS_SVH

  localparam int numVectors = 19;

  typedef struct packed {
    opcode_t opcode;
    funct_t funct;
    logic overflow;
    logic trapsOnOvf;
    logic [2:0] length;
    ctrlWord_t exec1;
    ctrlWord_t exec2;
  } vector_t;

  // Shared fetch and decode words
  localparam ctrlWord_t wFetch = '{iorD: addrPc, default: '0};
  localparam ctrlWord_t wIncr = '{pcWrite: 1'b1, aluOp: aluAdd, aluSrcA: srcAPc,
    aluSrcB: srcBFour, pcSource: pcAlu, default: '0};
  localparam ctrlWord_t wIrLoad = '{irWrite: 1'b1, default: '0};
  localparam ctrlWord_t wDecode = '{aWrite: 1'b1, bWrite: 1'b1, default: '0};
  localparam ctrlWord_t fetchWords [5] = '{wFetch, wFetch, wIncr, wIrLoad, wDecode};

  localparam ctrlWord_t wTrapOvf = '{epcWrite: 1'b1, pcWrite: 1'b1, pcSource: pcVector,
    excCause: causeOverflow, default: '0};
  localparam ctrlWord_t wTrapInv = '{epcWrite: 1'b1, pcWrite: 1'b1, pcSource: pcVector,
    excCause: causeInvalid, default: '0};

  // Execute words
  localparam ctrlWord_t wAdd = '{regWrite: 1'b1, aluOp: aluAdd, aluSrcA: srcARegA,
    aluSrcB: srcBRegB, regDst: dstRd, memToReg: wbAlu, default: '0};
  localparam ctrlWord_t wSub = '{regWrite: 1'b1, aluOp: aluSub, aluSrcA: srcARegA,
    aluSrcB: srcBRegB, regDst: dstRd, memToReg: wbAlu, default: '0};
  localparam ctrlWord_t wAnd = '{regWrite: 1'b1, aluOp: aluAnd, aluSrcA: srcARegA,
    aluSrcB: srcBRegB, regDst: dstRd, memToReg: wbAlu, default: '0};
  localparam ctrlWord_t wSlt = '{regWrite: 1'b1, aluOp: aluSlt, aluSrcA: srcARegA,
    aluSrcB: srcBRegB, regDst: dstRd, memToReg: wbSlt, default: '0};
  localparam ctrlWord_t wAddi = '{regWrite: 1'b1, aluOp: aluAdd, aluSrcA: srcARegA,
    aluSrcB: srcBImm, regDst: dstRt, memToReg: wbAlu, default: '0};
  localparam ctrlWord_t wSlti = '{regWrite: 1'b1, aluOp: aluSlt, aluSrcA: srcARegA,
    aluSrcB: srcBImm, regDst: dstRt, memToReg: wbSlt, default: '0};
  localparam ctrlWord_t wLui = '{regWrite: 1'b1, regDst: dstRt, memToReg: wbLui, default: '0};
  localparam ctrlWord_t wMfhi = '{regWrite: 1'b1, regDst: dstRd, memToReg: wbHi, default: '0};
  localparam ctrlWord_t wMflo = '{regWrite: 1'b1, regDst: dstRd, memToReg: wbLo, default: '0};
  localparam ctrlWord_t wJ = '{pcWrite: 1'b1, pcSource: pcJump, default: '0};
  localparam ctrlWord_t wJal = '{pcWrite: 1'b1, pcSource: pcJump, regWrite: 1'b1,
    regDst: dstRa, default: '0};
  localparam ctrlWord_t wJr = '{pcWrite: 1'b1, aluOp: aluPass, aluSrcA: srcARegA,
    pcSource: pcAlu, iorD: addrPc, default: '0};
  localparam ctrlWord_t wSw = '{memWrite: 1'b1, aluOp: aluAdd, aluSrcA: srcARegA,
    aluSrcB: srcBImm, iorD: addrAlu, default: '0};
  localparam ctrlWord_t wBreak = '{pcWrite: 1'b1, aluOp: aluSub, aluSrcA: srcAPc,
    aluSrcB: srcBFour, pcSource: pcAlu, iorD: addrPc, default: '0};
  localparam ctrlWord_t wRte = '{pcWrite: 1'b1, pcSource: pcEpc, iorD: addrPc, default: '0};
  localparam ctrlWord_t wXchgA = '{regWrite: 1'b1, regDst: dstRt, memToReg: wbXchgA, default: '0};
  localparam ctrlWord_t wXchgB = '{regWrite: 1'b1, regDst: dstRs, memToReg: wbXchgB, default: '0};

  vector_t vectors [numVectors];

  task automatic loadVectors();
    // opcode, funct, overflow, traps on overflow, length, execute words
    vectors[0] = '{opcodeRType, functAdd, 1'b1, 1'b1, 3'd6, wAdd, ctrlIdle};
    vectors[1] = '{opcodeRType, functSub, 1'b0, 1'b1, 3'd6, wSub, ctrlIdle};
    vectors[2] = '{opcodeRType, functAnd, 1'b1, 1'b0, 3'd6, wAnd, ctrlIdle};
    vectors[3] = '{opcodeRType, functSlt, 1'b1, 1'b0, 3'd6, wSlt, ctrlIdle};
    vectors[4] = '{opcodeRType, functMfhi, 1'b0, 1'b0, 3'd6, wMfhi, ctrlIdle};
    vectors[5] = '{opcodeRType, functMflo, 1'b1, 1'b0, 3'd6, wMflo, ctrlIdle};
    vectors[6] = '{opcodeRType, functJr, 1'b0, 1'b0, 3'd6, wJr, ctrlIdle};
    vectors[7] = '{opcodeRType, functBreak, 1'b0, 1'b0, 3'd6, wBreak, ctrlIdle};
    vectors[8] = '{opcodeRType, functRte, 1'b1, 1'b0, 3'd6, wRte, ctrlIdle};
    vectors[9] = '{opcodeRType, functXchg, 1'b1, 1'b0, 3'd7, wXchgA, wXchgB};
    vectors[10] = '{opcodeAddi, '0, 1'b1, 1'b1, 3'd6, wAddi, ctrlIdle};
    vectors[11] = '{opcodeAddiu, '0, 1'b1, 1'b0, 3'd6, wAddi, ctrlIdle};
    vectors[12] = '{opcodeSlti, '0, 1'b1, 1'b0, 3'd6, wSlti, ctrlIdle};
    vectors[13] = '{opcodeLui, '0, 1'b0, 1'b0, 3'd6, wLui, ctrlIdle};
    vectors[14] = '{opcodeSw, '0, 1'b1, 1'b0, 3'd6, wSw, ctrlIdle};
    vectors[15] = '{opcodeJ, '0, 1'b0, 1'b0, 3'd6, wJ, ctrlIdle};
    vectors[16] = '{opcodeJal, '0, 1'b1, 1'b0, 3'd6, wJal, ctrlIdle};
    // Dropped branch opcode, then dropped shift funct
    vectors[17] = '{6'b000100, '0, 1'b1, 1'b0, 3'd6, wTrapInv, ctrlIdle};
    vectors[18] = '{opcodeRType, 6'b000000, 1'b1, 1'b0, 3'd6, wTrapInv, ctrlIdle};
  endtask

`endif

//--- dv/controlUnitTb.sv
`default_nettype none

module controlUnitTb;

  import isaPkg::*;
  import ctrlPkg::*;

  `include "controlUnitVectors.svh"

  localparam int resetCycles = 10;
  localparam int randomPasses = 40;
  localparam int driveDelay = 2;
  localparam int peekDelay = 1;
  // No instruction is longer than 7 cycles
  localparam int timeoutCycles = resetCycles + 7 * (numVectors + randomPasses) + 20;

  logic clk;
  logic reset;
  opcode_t opcode;
  funct_t funct;
  logic overflow;
  ctrlWord_t ctrl;
  logic resetOut;
  logic [31:0] rngState;
  int cycleCount = 0;

  controlUnit UUT (
    .clk(clk),
    .reset(reset),
    .opcode(opcode),
    .funct(funct),
    .overflow(overflow),
    .ctrl(ctrl),
    .resetOut(resetOut)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      abortRun($sformatf("Timeout: the run hung after %0d cycles", cycleCount));
    end
  end

  task automatic checkCtrl(input ctrlWord_t actual, input ctrlWord_t expected, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("ERR @%0t: %s: ctrl %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic checkBit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abortRun($sformatf("ERR @%0t: %s: got %b, expected %b", $time, what, actual, expected));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Starts just after the edge that enters the first fetch cycle
  task automatic runInstr(input vector_t v, input logic ovf, input string name);
    ctrlWord_t expWords[$];
    logic ovfTrap;
    ovfTrap = v.trapsOnOvf && ovf;
    #(driveDelay - peekDelay);
    opcode = v.opcode;
    funct = v.funct;
    overflow = ovf;
    foreach (fetchWords[i]) begin
      expWords.push_back(fetchWords[i]);
    end
    expWords.push_back(v.exec1);
    if (v.length == 3'd7) begin
      expWords.push_back(v.exec2);
    end
    if (ovfTrap) begin
      expWords.push_back(wTrapOvf);
    end
    foreach (expWords[i]) begin
      @(negedge clk);
      checkCtrl(ctrl, expWords[i], $sformatf("%s cycle %0d", name, i + 1));
      checkBit(resetOut, 1'b0, $sformatf("%s resetOut", name));
      @(posedge clk);
    end
    #peekDelay;
    checkBit(ctrl == wFetch, 1'b1,
             $sformatf("%s fetch after %0d cycles", name, expWords.size()));
  endtask

  initial begin
    int idx;
    reset = 1'b1;
    opcode = '0;
    funct = '0;
    overflow = 1'b0;
    rngState = 32'h1bea;
    loadVectors();

    repeat (resetCycles) begin
      @(negedge clk);
      checkBit(resetOut, 1'b1, "resetOut during reset");
      checkCtrl(ctrl, ctrlIdle, "ctrl during reset");
      @(posedge clk);
    end
    #driveDelay;
    reset = 1'b0;
    // One more idle cycle after release
    @(negedge clk);
    checkBit(resetOut, 1'b1, "resetOut after release");
    checkCtrl(ctrl, ctrlIdle, "ctrl after release");
    @(posedge clk);
    #peekDelay;

    for (int i = 0; i < numVectors; i++) begin
      runInstr(vectors[i], vectors[i].overflow, $sformatf("vector %0d", i));
    end

    for (int p = 0; p < randomPasses; p++) begin
      rngState = xorshift(rngState);
      idx = rngState % numVectors;
      rngState = xorshift(rngState);
      runInstr(vectors[idx], rngState[0], $sformatf("random pass %0d vector %0d", p, idx));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+dv
common/isaPkg.sv
common/ctrlPkg.sv
logic/opcodeDecoder.sv
controlSequencer/controlSequencer.sv
logic/controlSignalTable.sv
logic/controlUnit.sv
dv/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing -Mdir obj_dir --top-module controlUnitTb -o simv -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
